//--- verilog/usiPkg.sv
// Shared bus widths, command layout and block address map for the system bus
package usiPkg;

	//--------------------------------------------------
	// Bus widths
	//--------------------------------------------------
	// Read and write data
	localparam int busDataBits = 32;
	// Full address, block byte plus register byte
	localparam int busAdrsBits = 16;
	// Upper address byte picks the block
	localparam int blockAdrsBits = 8;

	//--------------------------------------------------
	// Block address map
	//--------------------------------------------------
	localparam logic [blockAdrsBits-1:0] gpioBlockMap = 8'h01;
	localparam logic [blockAdrsBits-1:0] pwmBlockMap = 8'h02;

	// GPIO register offsets
	localparam logic [busAdrsBits-blockAdrsBits-1:0] gpioLedReg = 8'h00;
	localparam logic [busAdrsBits-blockAdrsBits-1:0] gpioInReg = 8'h01;

	// PWM register offsets
	localparam logic [busAdrsBits-blockAdrsBits-1:0] pwmPeriodReg = 8'h00;
	localparam logic [busAdrsBits-blockAdrsBits-1:0] pwmDutyReg = 8'h01;

	// Returned for any block outside the map
	localparam logic [busDataBits-1:0] unmappedData = 32'hDEAD_0000;

	//--------------------------------------------------
	// Command layout, 49 bits
	//--------------------------------------------------
	typedef struct packed
	{
		logic write;
		logic [busAdrsBits-1:0] adrs;
		logic [busDataBits-1:0] data;
	} usiCmd_t;

endpackage

//--- verilog/cmdQueue.sv
// Credit-backed command queue for one bus master channel
`timescale 1ns/1ns

module cmdQueue #(
	parameter int cmdDepth = 4
)(
	input  logic sysClk,
	input  logic rstN,
	input  logic push,
	input  usiPkg::usiCmd_t pushCmd,
	input  logic pop,
	output usiPkg::usiCmd_t headCmd,
	output logic notEmpty,
	output logic credit
);

	// Pointers wrap naturally, depth is a power of two
	localparam int ptrBits = (cmdDepth > 1) ? $clog2(cmdDepth) : 1;
	localparam int cntBits = $clog2(cmdDepth + 1);

	usiPkg::usiCmd_t mem [cmdDepth];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [cntBits-1:0] count;

	//--------------------------------------------------
	// Storage, no reset on payload
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (push)
		begin
			mem[wrPtr] <= pushCmd;
		end
	end

	// Head read straight from the array
	assign headCmd = mem[rdPtr];
	assign notEmpty = (count != '0);

	//--------------------------------------------------
	// Pointers, fill count and credit return
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Simultaneous push and pop leaves count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// One credit back per entry that left, a cycle later
			credit <= pop;
		end
	end

	// Master must hold a credit before it pushes
	pushWithoutCredit: assert property (@(posedge sysClk) disable iff (!rstN)
		push |-> (count < cntBits'(cmdDepth)));

endmodule

//--- verilog/usiArbiter.sv
// Round-robin arbiter issuing queued mcu and dbg commands onto the system bus
`timescale 1ns/1ns

module usiArbiter #(
	parameter int cmdDepth = 4
)(
	input  logic sysClk,
	input  logic rstN,
	// Command entry
	input  logic mcuPush,
	input  usiPkg::usiCmd_t mcuCmd,
	input  logic dbgPush,
	input  usiPkg::usiCmd_t dbgCmd,
	output logic mcuCredit,
	output logic dbgCredit,
	// Bus master side
	output logic busValid,
	output logic busWrite,
	output logic [usiPkg::busAdrsBits-1:0] busAdrs,
	output logic [usiPkg::busDataBits-1:0] busWd,
	input  logic busRdValid,
	input  logic [usiPkg::busDataBits-1:0] busRd,
	// Responses back to the owners
	output logic mcuRspValid,
	output logic dbgRspValid,
	output logic [usiPkg::busDataBits-1:0] rspData
);

	usiPkg::usiCmd_t mcuHead;
	usiPkg::usiCmd_t dbgHead;
	usiPkg::usiCmd_t issueCmd;
	logic mcuNotEmpty;
	logic dbgNotEmpty;
	logic mcuGrant;
	logic dbgGrant;
	// Set when dbg won the last issue
	logic lastDbg;
	// Owner of the command now on the bus
	logic ownerValid;
	logic ownerDbg;

	//--------------------------------------------------
	// Per channel queues
	//--------------------------------------------------
	cmdQueue #(
		.cmdDepth (cmdDepth)
	) mcuQueue (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.push     (mcuPush),
		.pushCmd  (mcuCmd),
		.pop      (mcuGrant),
		.headCmd  (mcuHead),
		.notEmpty (mcuNotEmpty),
		.credit   (mcuCredit)
	);

	cmdQueue #(
		.cmdDepth (cmdDepth)
	) dbgQueue (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.push     (dbgPush),
		.pushCmd  (dbgCmd),
		.pop      (dbgGrant),
		.headCmd  (dbgHead),
		.notEmpty (dbgNotEmpty),
		.credit   (dbgCredit)
	);

	//--------------------------------------------------
	// Grant and issue
	//--------------------------------------------------
	// Under contention the side that lost last time wins
	assign mcuGrant = mcuNotEmpty && (!dbgNotEmpty || lastDbg);
	assign dbgGrant = dbgNotEmpty && (!mcuNotEmpty || !lastDbg);

	assign issueCmd = dbgGrant ? dbgHead : mcuHead;
	assign busValid = mcuGrant || dbgGrant;
	assign busWrite = issueCmd.write;
	assign busAdrs = issueCmd.adrs;
	assign busWd = issueCmd.data;

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			lastDbg <= 1'b0;
			ownerValid <= 1'b0;
			ownerDbg <= 1'b0;
		end
		else
		begin
			if (busValid)
			begin
				lastDbg <= dbgGrant;
			end
			// One stage pipe, matches the slave response latency
			ownerValid <= busValid;
			ownerDbg <= dbgGrant;
		end
	end

	// Steer the response to whoever issued it
	assign mcuRspValid = busRdValid && ownerValid && !ownerDbg;
	assign dbgRspValid = busRdValid && ownerValid && ownerDbg;
	assign rspData = busRd;

	onePopPerCycle: assert property (@(posedge sysClk) disable iff (!rstN)
		!(mcuGrant && dbgGrant));

	// Every bus response needs a command issued the cycle before
	noOrphanResponse: assert property (@(posedge sysClk) disable iff (!rstN)
		busRdValid |-> ownerValid);

endmodule

//--- verilog/usiBus.sv
// System bus decoder with block selects, default responder and read data merge
`timescale 1ns/1ns

module usiBus (
	input  logic sysClk,
	input  logic rstN,
	input  logic busValid,
	input  logic [usiPkg::busAdrsBits-1:0] busAdrs,
	output logic gpioSel,
	output logic pwmSel,
	input  logic gpioRdValid,
	input  logic [usiPkg::busDataBits-1:0] gpioRd,
	input  logic pwmRdValid,
	input  logic [usiPkg::busDataBits-1:0] pwmRd,
	output logic busRdValid,
	output logic [usiPkg::busDataBits-1:0] busRd
);

	logic [usiPkg::blockAdrsBits-1:0] blockSel;
	logic defSel;
	logic defRdValid;

	//--------------------------------------------------
	// Block decode
	//--------------------------------------------------
	// Upper address byte
	assign blockSel = busAdrs[usiPkg::busAdrsBits-1 -: usiPkg::blockAdrsBits];

	assign gpioSel = busValid && (blockSel == usiPkg::gpioBlockMap);
	assign pwmSel = busValid && (blockSel == usiPkg::pwmBlockMap);
	// Anything outside the map lands here
	assign defSel = busValid && !gpioSel && !pwmSel;

	// Default responder, same one cycle latency as a slave
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			defRdValid <= 1'b0;
		end
		else
		begin
			defRdValid <= defSel;
		end
	end

	//--------------------------------------------------
	// Response merge
	//--------------------------------------------------
	assign busRdValid = gpioRdValid || pwmRdValid || defRdValid;

	always_comb
	begin
		if (gpioRdValid)
		begin
			busRd = gpioRd;
		end
		else if (pwmRdValid)
		begin
			busRd = pwmRd;
		end
		else if (defRdValid)
		begin
			busRd = usiPkg::unmappedData;
		end
		else
		begin
			busRd = '0;
		end
	end

	// One select per command, so responses never collide
	singleResponder: assert property (@(posedge sysClk) disable iff (!rstN)
		$onehot0({gpioRdValid, pwmRdValid, defRdValid}));

endmodule

//--- verilog/gpioBlock.sv
// GPIO slave driving the LED outputs and reading synchronized inputs
`timescale 1ns/1ns

module gpioBlock (
	input  logic sysClk,
	input  logic rstN,
	input  logic sel,
	input  logic busWrite,
	input  logic [7:0] busRegAdrs,
	input  logic [usiPkg::busDataBits-1:0] busWd,
	input  logic [7:0] gpioIn,
	output logic [7:0] ledOut,
	output logic rdValid,
	output logic [usiPkg::busDataBits-1:0] rdData
);

	// Two flop synchronizer on the pins
	logic [7:0] gpioMeta;
	logic [7:0] gpioSync;

	always_ff @(posedge sysClk)
	begin
		gpioMeta <= gpioIn;
		gpioSync <= gpioMeta;
	end

	//--------------------------------------------------
	// Register access
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ledOut <= '0;
			rdValid <= 1'b0;
		end
		else
		begin
			// Only the low data byte reaches the LEDs
			if (sel && busWrite && (busRegAdrs == usiPkg::gpioLedReg))
			begin
				ledOut <= busWd[7:0];
			end
			rdValid <= sel;
		end
	end

	// Response data, writes and unknown offsets give zero
	always_ff @(posedge sysClk)
	begin
		rdData <= '0;
		if (sel && !busWrite)
		begin
			case (busRegAdrs)
				usiPkg::gpioLedReg: rdData[7:0] <= ledOut;
				usiPkg::gpioInReg: rdData[7:0] <= gpioSync;
				default: rdData <= '0;
			endcase
		end
	end

endmodule

//--- verilog/pwmBlock.sv
// PWM backlight slave with period and duty registers
`timescale 1ns/1ns

module pwmBlock #(
	parameter int pwmBits = 8
)(
	input  logic sysClk,
	input  logic rstN,
	input  logic sel,
	input  logic busWrite,
	input  logic [7:0] busRegAdrs,
	input  logic [usiPkg::busDataBits-1:0] busWd,
	output logic pwmOut,
	output logic rdValid,
	output logic [usiPkg::busDataBits-1:0] rdData
);

	logic [pwmBits-1:0] periodReg;
	logic [pwmBits-1:0] dutyReg;
	logic [pwmBits-1:0] pwmCnt;

	//--------------------------------------------------
	// Register writes
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			periodReg <= '0;
			dutyReg <= '0;
			rdValid <= 1'b0;
		end
		else
		begin
			if (sel && busWrite)
			begin
				case (busRegAdrs)
					usiPkg::pwmPeriodReg: periodReg <= busWd[pwmBits-1:0];
					usiPkg::pwmDutyReg: dutyReg <= busWd[pwmBits-1:0];
					default: ;
				endcase
			end
			rdValid <= sel;
		end
	end

	// Readback zero extended, writes answer with zero
	always_ff @(posedge sysClk)
	begin
		rdData <= '0;
		if (sel && !busWrite)
		begin
			case (busRegAdrs)
				usiPkg::pwmPeriodReg: rdData[pwmBits-1:0] <= periodReg;
				usiPkg::pwmDutyReg: rdData[pwmBits-1:0] <= dutyReg;
				default: rdData <= '0;
			endcase
		end
	end

	//--------------------------------------------------
	// Counter and output
	//--------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			pwmCnt <= '0;
			pwmOut <= 1'b0;
		end
		else if (periodReg == '0)
		begin
			// Period zero parks the output low
			pwmCnt <= '0;
			pwmOut <= 1'b0;
		end
		else
		begin
			// Also catches a period shrunk below the count
			if (pwmCnt >= periodReg - 1'b1)
			begin
				pwmCnt <= '0;
			end
			else
			begin
				pwmCnt <= pwmCnt + 1'b1;
			end
			pwmOut <= (pwmCnt < dutyReg);
		end
	end

endmodule

//--- verilog/processer.sv
// Processor support subsystem joining the command queues, bus and peripherals
`timescale 1ns/1ns

module processer #(
	parameter int cmdDepth = 4,
	parameter int pwmBits = 8
)(
	input  logic sysClk,
	input  logic rstN,
	// mcu command channel
	input  logic mcuCmdValid,
	input  logic mcuCmdWrite,
	input  logic [usiPkg::busAdrsBits-1:0] mcuCmdAdrs,
	input  logic [usiPkg::busDataBits-1:0] mcuCmdData,
	output logic mcuCmdCredit,
	// dbg command channel
	input  logic dbgCmdValid,
	input  logic dbgCmdWrite,
	input  logic [usiPkg::busAdrsBits-1:0] dbgCmdAdrs,
	input  logic [usiPkg::busDataBits-1:0] dbgCmdData,
	output logic dbgCmdCredit,
	// Responses
	output logic mcuRspValid,
	output logic dbgRspValid,
	output logic [usiPkg::busDataBits-1:0] rspData,
	// Pins
	input  logic [7:0] gpioIn,
	output logic [7:0] ledOut,
	output logic pwmOut
);

	usiPkg::usiCmd_t mcuCmd;
	usiPkg::usiCmd_t dbgCmd;
	logic busValid;
	logic busWrite;
	logic [usiPkg::busAdrsBits-1:0] busAdrs;
	logic [usiPkg::busDataBits-1:0] busWd;
	logic busRdValid;
	logic [usiPkg::busDataBits-1:0] busRd;
	logic gpioSel;
	logic pwmSel;
	logic gpioRdValid;
	logic [usiPkg::busDataBits-1:0] gpioRd;
	logic pwmRdValid;
	logic [usiPkg::busDataBits-1:0] pwmRd;

	// Pack the loose command ports
	assign mcuCmd = '{write: mcuCmdWrite, adrs: mcuCmdAdrs, data: mcuCmdData};
	assign dbgCmd = '{write: dbgCmdWrite, adrs: dbgCmdAdrs, data: dbgCmdData};

	//--------------------------------------------------
	// Arbiter and bus
	//--------------------------------------------------
	usiArbiter #(
		.cmdDepth (cmdDepth)
	) arbiter (
		.sysClk (sysClk), .rstN (rstN),
		.mcuPush (mcuCmdValid), .mcuCmd (mcuCmd),
		.dbgPush (dbgCmdValid), .dbgCmd (dbgCmd),
		.mcuCredit (mcuCmdCredit), .dbgCredit (dbgCmdCredit),
		.busValid (busValid), .busWrite (busWrite),
		.busAdrs (busAdrs), .busWd (busWd),
		.busRdValid (busRdValid), .busRd (busRd),
		.mcuRspValid (mcuRspValid), .dbgRspValid (dbgRspValid),
		.rspData (rspData)
	);

	usiBus bus (
		.sysClk (sysClk), .rstN (rstN),
		.busValid (busValid), .busAdrs (busAdrs),
		.gpioSel (gpioSel), .pwmSel (pwmSel),
		.gpioRdValid (gpioRdValid), .gpioRd (gpioRd),
		.pwmRdValid (pwmRdValid), .pwmRd (pwmRd),
		.busRdValid (busRdValid), .busRd (busRd)
	);

	//--------------------------------------------------
	// Slaves, register byte is the low address byte
	//--------------------------------------------------
	gpioBlock gpio (
		.sysClk (sysClk), .rstN (rstN),
		.sel (gpioSel), .busWrite (busWrite),
		.busRegAdrs (busAdrs[7:0]), .busWd (busWd),
		.gpioIn (gpioIn), .ledOut (ledOut),
		.rdValid (gpioRdValid), .rdData (gpioRd)
	);

	pwmBlock #(
		.pwmBits (pwmBits)
	) pwm (
		.sysClk (sysClk), .rstN (rstN),
		.sel (pwmSel), .busWrite (busWrite),
		.busRegAdrs (busAdrs[7:0]), .busWd (busWd),
		.pwmOut (pwmOut),
		.rdValid (pwmRdValid), .rdData (pwmRd)
	);

endmodule

//--- verif/processerTb.sv
// Directed testbench for the processor support subsystem, two masters on one bus
`timescale 1ns/1ns

module processerTb;

	localparam int cmdDepth = 4;
	localparam int pwmBits = 8;
	localparam logic [usiPkg::busDataBits-1:0] pwmPeriod = 32'd10;
	// Whole run is a few hundred cycles
	localparam int maxCycles = 3000;

	logic sysClk = 1'b0;
	logic rstN;
	logic mcuCmdValid;
	logic mcuCmdWrite;
	logic [usiPkg::busAdrsBits-1:0] mcuCmdAdrs;
	logic [usiPkg::busDataBits-1:0] mcuCmdData;
	logic mcuCmdCredit;
	logic dbgCmdValid;
	logic dbgCmdWrite;
	logic [usiPkg::busAdrsBits-1:0] dbgCmdAdrs;
	logic [usiPkg::busDataBits-1:0] dbgCmdData;
	logic dbgCmdCredit;
	logic mcuRspValid;
	logic dbgRspValid;
	logic [usiPkg::busDataBits-1:0] rspData;
	logic [7:0] gpioIn;
	logic [7:0] ledOut;
	logic pwmOut;

	// Master side credit and response bookkeeping
	int mcuCredits = cmdDepth;
	int dbgCredits = cmdDepth;
	int mcuCreditPulses = 0;
	int dbgCreditPulses = 0;
	int mcuLastRsp = 0;
	int dbgLastRsp = 0;
	int cycleCount = 0;
	logic [usiPkg::busDataBits-1:0] mcuRspQ [$];
	logic [usiPkg::busDataBits-1:0] dbgRspQ [$];
	logic [15:0] lfsrState;
	// Values last written to the registers
	logic [7:0] ledShadow;
	logic [7:0] pinShadow;
	logic [7:0] dutyShadow;

	processer #(
		.cmdDepth (cmdDepth),
		.pwmBits  (pwmBits)
	) u_dut (
		.sysClk       (sysClk),
		.rstN         (rstN),
		.mcuCmdValid  (mcuCmdValid),
		.mcuCmdWrite  (mcuCmdWrite),
		.mcuCmdAdrs   (mcuCmdAdrs),
		.mcuCmdData   (mcuCmdData),
		.mcuCmdCredit (mcuCmdCredit),
		.dbgCmdValid  (dbgCmdValid),
		.dbgCmdWrite  (dbgCmdWrite),
		.dbgCmdAdrs   (dbgCmdAdrs),
		.dbgCmdData   (dbgCmdData),
		.dbgCmdCredit (dbgCmdCredit),
		.mcuRspValid  (mcuRspValid),
		.dbgRspValid  (dbgRspValid),
		.rspData      (rspData),
		.gpioIn       (gpioIn),
		.ledOut       (ledOut),
		.pwmOut       (pwmOut)
	);

	always #50 sysClk = ~sysClk;

	//--------------------------------------------------
	// Monitor and timeout
	//--------------------------------------------------
	// Sampled mid cycle, away from the clock edge
	always @(negedge sysClk)
	begin
		if (rstN)
		begin
			if (mcuCmdCredit)
			begin
				mcuCredits++;
				mcuCreditPulses++;
			end
			if (dbgCmdCredit)
			begin
				dbgCredits++;
				dbgCreditPulses++;
			end
			if (mcuRspValid)
			begin
				mcuRspQ.push_back(rspData);
				mcuLastRsp = cycleCount;
			end
			if (dbgRspValid)
			begin
				dbgRspQ.push_back(rspData);
				dbgLastRsp = cycleCount;
			end
		end
	end

	always @(posedge sysClk)
	begin
		cycleCount++;
		if (cycleCount >= maxCycles)
		begin
			failRun($sformatf("Timeout after %0d cycles, DUT stopped answering", cycleCount));
		end
	end

	//--------------------------------------------------
	// Checks and stimulus helpers
	//--------------------------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkData(input string what, input logic [usiPkg::busDataBits-1:0] got,
		input logic [usiPkg::busDataBits-1:0] exp);
		if (got !== exp)
		begin
			failRun($sformatf("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkLed(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			failRun($sformatf("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic checkCount(input string what, input int got, input int exp);
		if (got != exp)
		begin
			failRun($sformatf("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp));
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken, result right aligned
	function automatic logic [usiPkg::busDataBits-1:0] randWord(input int nBits);
		logic [usiPkg::busDataBits-1:0] w;
		w = '0;
		for (int i = 0; i < nBits; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			w = {w[usiPkg::busDataBits-2:0], lfsrState[0]};
		end
		return w;
	endfunction

	// Waits for a credit, pushes for one cycle
	task automatic sendCmd(input bit onDbg, input logic write,
		input logic [usiPkg::busAdrsBits-1:0] adrs, input logic [usiPkg::busDataBits-1:0] data);
		if (onDbg)
		begin
			while (dbgCredits == 0)
			begin
				@(posedge sysClk);
				#1;
			end
			dbgCmdValid = 1'b1;
			dbgCmdWrite = write;
			dbgCmdAdrs = adrs;
			dbgCmdData = data;
			dbgCredits--;
		end
		else
		begin
			while (mcuCredits == 0)
			begin
				@(posedge sysClk);
				#1;
			end
			mcuCmdValid = 1'b1;
			mcuCmdWrite = write;
			mcuCmdAdrs = adrs;
			mcuCmdData = data;
			mcuCredits--;
		end
		@(posedge sysClk);
		#1;
		if (onDbg)
		begin
			dbgCmdValid = 1'b0;
		end
		else
		begin
			mcuCmdValid = 1'b0;
		end
	endtask

	// Oldest response of the channel, timeout covers a lost one
	task automatic waitRsp(input bit onDbg, output logic [usiPkg::busDataBits-1:0] data);
		while ((onDbg ? dbgRspQ.size() : mcuRspQ.size()) == 0)
		begin
			@(posedge sysClk);
			#1;
		end
		if (onDbg)
		begin
			data = dbgRspQ.pop_front();
		end
		else
		begin
			data = mcuRspQ.pop_front();
		end
	endtask

	task automatic writeReg(input bit onDbg, input logic [usiPkg::busAdrsBits-1:0] adrs,
		input logic [usiPkg::busDataBits-1:0] data, input string what);
		logic [usiPkg::busDataBits-1:0] rd;
		sendCmd(onDbg, 1'b1, adrs, data);
		waitRsp(onDbg, rd);
		// Writes answer with zero data
		checkData(what, rd, '0);
	endtask

	task automatic readReg(input bit onDbg, input logic [usiPkg::busAdrsBits-1:0] adrs,
		input logic [usiPkg::busDataBits-1:0] exp, input string what);
		logic [usiPkg::busDataBits-1:0] rd;
		sendCmd(onDbg, 1'b0, adrs, '0);
		waitRsp(onDbg, rd);
		checkData(what, rd, exp);
	endtask

	//--------------------------------------------------
	// Tests
	//--------------------------------------------------
	task automatic checkResetState();
		checkLed("ledOut after reset", ledOut, 8'h00);
		checkCount("pwmOut after reset", int'(pwmOut), 0);
		checkCount("mcuRspValid after reset", int'(mcuRspValid), 0);
		checkCount("dbgRspValid after reset", int'(dbgRspValid), 0);
		// Idle bus must stay quiet
		repeat (4)
		begin
			@(posedge sysClk);
			#1;
		end
		checkCount("responses with no command", mcuRspQ.size() + dbgRspQ.size(), 0);
		checkCount("credit pulses with no command", mcuCreditPulses + dbgCreditPulses, 0);
	endtask

	task automatic testGpio();
		logic [usiPkg::busDataBits-1:0] w;
		w = randWord(usiPkg::busDataBits);
		ledShadow = w[7:0];
		writeReg(1'b0, {usiPkg::gpioBlockMap, usiPkg::gpioLedReg}, w, "LED write");
		checkLed("ledOut after write", ledOut, ledShadow);
		readReg(1'b0, {usiPkg::gpioBlockMap, usiPkg::gpioLedReg}, {24'h0, ledShadow}, "LED read");
		w = randWord(8);
		pinShadow = w[7:0];
		gpioIn = pinShadow;
		// Covers the two flop synchronizer
		repeat (3)
		begin
			@(posedge sysClk);
			#1;
		end
		readReg(1'b1, {usiPkg::gpioBlockMap, usiPkg::gpioInReg}, {24'h0, pinShadow}, "input read");
	endtask

	task automatic testPwm();
		int highCount;
		highCount = 0;
		dutyShadow = 8'd3;
		writeReg(1'b0, {usiPkg::pwmBlockMap, usiPkg::pwmPeriodReg}, pwmPeriod, "period write");
		writeReg(1'b0, {usiPkg::pwmBlockMap, usiPkg::pwmDutyReg}, {24'h0, dutyShadow},
			"duty write");
		// Ten full periods, 3 of 10 high
		repeat (100)
		begin
			@(negedge sysClk);
			if (pwmOut)
			begin
				highCount++;
			end
		end
		@(posedge sysClk);
		#1;
		checkCount("PWM high cycles in 100", highCount, 30);
		readReg(1'b1, {usiPkg::pwmBlockMap, usiPkg::pwmPeriodReg}, pwmPeriod, "period read");
		readReg(1'b1, {usiPkg::pwmBlockMap, usiPkg::pwmDutyReg}, {24'h0, dutyShadow}, "duty read");
	endtask

	task automatic testUnmapped();
		readReg(1'b1, {8'h05, 8'h00}, usiPkg::unmappedData, "unmapped block read");
	endtask

	task automatic testCredits();
		logic [usiPkg::busAdrsBits-1:0] adrs [cmdDepth];
		logic [usiPkg::busDataBits-1:0] exp [cmdDepth];
		logic [usiPkg::busDataBits-1:0] rd;
		mcuCreditPulses = 0;
		// Cycle through four registers with known contents
		for (int i = 0; i < cmdDepth; i++)
		begin
			case (i % 4)
				0:
				begin
					adrs[i] = {usiPkg::gpioBlockMap, usiPkg::gpioLedReg};
					exp[i] = {24'h0, ledShadow};
				end
				1:
				begin
					adrs[i] = {usiPkg::gpioBlockMap, usiPkg::gpioInReg};
					exp[i] = {24'h0, pinShadow};
				end
				2:
				begin
					adrs[i] = {usiPkg::pwmBlockMap, usiPkg::pwmPeriodReg};
					exp[i] = pwmPeriod;
				end
				default:
				begin
					adrs[i] = {usiPkg::pwmBlockMap, usiPkg::pwmDutyReg};
					exp[i] = {24'h0, dutyShadow};
				end
			endcase
		end
		// Back to back, spends every starting credit
		for (int i = 0; i < cmdDepth; i++)
		begin
			sendCmd(1'b0, 1'b0, adrs[i], '0);
		end
		for (int i = 0; i < cmdDepth; i++)
		begin
			waitRsp(1'b0, rd);
			checkData($sformatf("burst read %0d", i), rd, exp[i]);
		end
		repeat (2)
		begin
			@(posedge sysClk);
			#1;
		end
		checkCount("credit pulses after burst", mcuCreditPulses, cmdDepth);
		checkCount("mcu credits after burst", mcuCredits, cmdDepth);
	endtask

	task automatic testArbitration();
		logic [usiPkg::busDataBits-1:0] w;
		logic [usiPkg::busDataBits-1:0] rd;
		int gap;
		w = randWord(16);
		ledShadow = w[7:0];
		dutyShadow = (w[15:8] == w[7:0]) ? ~w[7:0] : w[15:8];
		writeReg(1'b0, {usiPkg::gpioBlockMap, usiPkg::gpioLedReg}, {24'h0, ledShadow}, "LED write");
		writeReg(1'b1, {usiPkg::pwmBlockMap, usiPkg::pwmDutyReg}, {24'h0, dutyShadow},
			"duty write");
		mcuCreditPulses = 0;
		dbgCreditPulses = 0;
		// Both masters start in the same cycle
		fork
			for (int i = 0; i < 4; i++)
			begin
				sendCmd(1'b0, 1'b0, (i % 2 == 0) ? {usiPkg::gpioBlockMap, usiPkg::gpioLedReg} :
					{usiPkg::gpioBlockMap, usiPkg::gpioInReg}, '0);
			end
			for (int i = 0; i < 4; i++)
			begin
				sendCmd(1'b1, 1'b0, (i % 2 == 0) ? {usiPkg::pwmBlockMap, usiPkg::pwmDutyReg} :
					{usiPkg::pwmBlockMap, usiPkg::pwmPeriodReg}, '0);
			end
		join
		for (int i = 0; i < 4; i++)
		begin
			waitRsp(1'b0, rd);
			checkData($sformatf("mcu contended read %0d", i), rd,
				(i % 2 == 0) ? {24'h0, ledShadow} : {24'h0, pinShadow});
		end
		for (int i = 0; i < 4; i++)
		begin
			waitRsp(1'b1, rd);
			checkData($sformatf("dbg contended read %0d", i), rd,
				(i % 2 == 0) ? {24'h0, dutyShadow} : pwmPeriod);
		end
		repeat (2)
		begin
			@(posedge sysClk);
			#1;
		end
		checkCount("mcu credit pulses under contention", mcuCreditPulses, 4);
		checkCount("dbg credit pulses under contention", dbgCreditPulses, 4);
		// Alternating grants finish one cycle apart
		gap = mcuLastRsp - dbgLastRsp;
		if (gap < 0)
		begin
			gap = -gap;
		end
		checkCount("cycles between last mcu and dbg responses", gap, 1);
	endtask

	//--------------------------------------------------
	// Sequence
	//--------------------------------------------------
	initial
	begin
		rstN = 1'b0;
		mcuCmdValid = 1'b0;
		mcuCmdWrite = 1'b0;
		mcuCmdAdrs = '0;
		mcuCmdData = '0;
		dbgCmdValid = 1'b0;
		dbgCmdWrite = 1'b0;
		dbgCmdAdrs = '0;
		dbgCmdData = '0;
		gpioIn = '0;
		lfsrState = 16'd52000;
		repeat (8) @(posedge sysClk);
		#1;
		rstN = 1'b1;
		checkResetState();
		testGpio();
		testPwm();
		testUnmapped();
		testCredits();
		testArbitration();
		$display("All tests passed");
		$finish;
	end

endmodule

//--- verilog.f
verilog/usiPkg.sv
verilog/cmdQueue.sv
verilog/usiArbiter.sv
verilog/usiBus.sv
verilog/gpioBlock.sv
verilog/pwmBlock.sv
verilog/processer.sv
verif/processerTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module processerTb -f verilog.f -o simProcesser
out=$(./obj_dir/simProcesser 2>&1) || true
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
